/* compile.f */
periph_pkg.sv
periph_bus_fsm.sv
periph_gpio.sv
periph_timer.sv
periph_edge_counter.sv
periph_subsystem.sv
periph_asserts.sv
periph_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module periph_tb \
    -f compile.f \
    -o periph_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/periph_sim > sim.log 2>&1
cat sim.log

grep -qx "Verification passed" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* periph_tb.sv */
//==========================================================================
// Testbench for the peripheral subsystem that drives the core bus and pins
// Checks reads against a register model and prints one line per test
//==========================================================================
`default_nettype none

module periph_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import periph_pkg::*;

    localparam int cycle_limit = 4000;

    logic        clk;
    logic        rst_n;
    bus_req_t    req;
    logic        read_complete;
    logic [7:0]  ui_in;
    logic [31:0] data_out;
    logic        data_ready;
    logic [7:0]  uo_out;
    irq_t        irq;

    int unsigned cycle_count;
    int          errors;
    int          tests_run;
    int          tests_failed;

    // Register model
    logic [7:0]  m_gpio_out;
    logic [4:0]  m_sel [8];
    logic [7:0]  m_ui;
    logic [31:0] m_count;
    logic [31:0] m_cmp;
    logic [1:0]  m_ctrl;
    logic        m_stat;
    logic        m_match_out;
    logic [2:0]  m_edge_sel;
    logic [7:0]  m_edge_cnt;

    localparam bus_req_t idle_req = '{address: '0, wdata: '0,
                                      write_size: size_none, read_size: size_none};

    periph_subsystem i_periph_subsystem (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .read_complete (read_complete),
        .ui_in         (ui_in),
        .data_out      (data_out),
        .data_ready    (data_ready),
        .uo_out        (uo_out),
        .irq           (irq)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [10:0] word_addr(input logic [3:0] slot, input logic [5:0] off);
        return {1'b0, slot, off};
    endfunction

    function automatic logic [10:0] byte_addr(input logic [3:0] slot, input logic [3:0] off);
        return {3'b100, slot, off};
    endfunction

    // Expected read data from the model
    function automatic logic [31:0] ref_read(input logic [10:0] addr);
        logic [31:0] val;
        val = '0;
        if (addr[10]) begin
            if (addr[7:4] == 4'd0 && addr[3:0] == 4'h0) val = {29'h0, m_edge_sel};
            if (addr[7:4] == 4'd0 && addr[3:0] == 4'h1) val = {24'h0, m_edge_cnt};
        end else if (addr[9:6] == 4'd1) begin
            if (addr[5:0] == 6'h00) val = {24'h0, m_gpio_out};
            if (addr[5:0] == 6'h04) val = {24'h0, m_ui};
            for (int i = 0; i < 8; i++) begin
                if (addr[5:0] == 6'(32 + 4 * i)) val = {27'h0, m_sel[i]};
            end
        end else if (addr[9:6] == 4'd2) begin
            case (addr[5:0])
                6'h00: val = m_count;
                6'h04: val = m_cmp;
                6'h08: val = {30'h0, m_ctrl};
                6'h0C: val = {31'h0, m_stat};
                default: val = '0;
            endcase
        end
        return val;
    endfunction

    // Expected output pins from the model selects
    function automatic logic [7:0] ref_uo();
        logic [7:0] pins;
        for (int i = 0; i < 8; i++) begin
            case (m_sel[i])
                5'h01: pins[i] = m_gpio_out[i];
                5'h02: pins[i] = (i == 0) ? m_match_out : 1'b0;
                5'h10: pins[i] = m_edge_cnt[i];
                default: pins[i] = 1'b0;
            endcase
        end
        return pins;
    endfunction

    function automatic logic [31:0] narrow(input logic [31:0] old, input logic [31:0] d,
                                           input access_size_e size);
        if (size == size_byte) return {old[31:8], d[7:0]};
        if (size == size_half) return {old[31:16], d[15:0]};
        return d;
    endfunction

    task automatic note_failure(input string msg);
        $display("%s (at %0t)", msg, $time);
        errors++;
    endtask

    task automatic check_word(input string label, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, label, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string label, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%02h expected 0x%02h", $time, label, got, exp);
            errors++;
        end
    endtask

    task automatic check_irq(input string label, input irq_t got, input irq_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%02h expected 0x%02h", $time, label, got, exp);
            errors++;
        end
    endtask

    task automatic model_write(input logic [10:0] addr, input logic [31:0] d,
                               input access_size_e size);
        if (addr[10]) begin
            if (addr[7:4] == 4'd0 && addr[3:0] == 4'h0) m_edge_sel = d[2:0];
            if (addr[7:4] == 4'd0 && addr[3:0] == 4'h1) m_edge_cnt = '0;
        end else if (addr[9:6] == 4'd1) begin
            if (addr[5:0] == 6'h00) m_gpio_out = d[7:0];
            for (int i = 0; i < 8; i++) begin
                if (addr[5:0] == 6'(32 + 4 * i)) m_sel[i] = d[4:0];
            end
        end else if (addr[9:6] == 4'd2) begin
            case (addr[5:0])
                6'h00: m_count = narrow(m_count, d, size);
                6'h04: m_cmp = narrow(m_cmp, d, size);
                6'h08: m_ctrl = d[1:0];
                6'h0C: if (d[0]) m_stat = 1'b0;
                default: ;
            endcase
        end
    endtask

    task automatic bus_write(input logic [10:0] addr, input logic [31:0] d,
                             input access_size_e size);
        @(posedge clk);
        req <= '{address: addr, wdata: d, write_size: size, read_size: size_none};
        @(negedge clk);
        if (!data_ready) note_failure("Write was not acknowledged in its own cycle");
        @(posedge clk);
        req <= idle_req;
        model_write(addr, d, size);
    endtask

    task automatic bus_read(input logic [10:0] addr, input access_size_e size,
                            output logic [31:0] d);
        int          waits;
        logic [31:0] held;
        @(posedge clk);
        req <= '{address: addr, wdata: '0, write_size: size_none, read_size: size};
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!data_ready && waits < 8);
        if (!data_ready) begin
            note_failure($sformatf("Read of address 0x%03h never got data_ready", addr));
        end else if (waits != 2) begin
            note_failure($sformatf("data_ready came %0d cycles after the read, not 1", waits - 1));
        end
        held = data_out;
        @(posedge clk);
        req           <= idle_req;
        read_complete <= 1'b1;
        @(negedge clk);
        if (data_ready) note_failure("data_ready stayed high after the read was taken");
        check_word("data_out", data_out, held);
        @(posedge clk);
        read_complete <= 1'b0;
        d = held;
    endtask

    task automatic read_and_check(input logic [10:0] addr, input access_size_e size);
        logic [31:0] got;
        bus_read(addr, size, got);
        check_word($sformatf("read 0x%03h", addr), got, ref_read(addr));
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        int          start;
        int          n;
        int          k;
        int          waits;
        int          pin;
        logic [31:0] rd;
        logic [4:0]  choice;
        irq_t        exp_irq;

        clk           = 1'b0;
        rst_n         = 1'b0;
        req           = idle_req;
        read_complete = 1'b0;
        ui_in         = '0;
        cycle_count   = 0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        void'($urandom(70480));

        m_gpio_out  = '0;
        m_ui        = '0;
        m_count     = '0;
        m_cmp       = '1;
        m_ctrl      = '0;
        m_stat      = 1'b0;
        m_match_out = 1'b0;
        m_edge_sel  = '0;
        m_edge_cnt  = '0;
        for (int i = 0; i < 8; i++) begin
            m_sel[i] = (i == 0) ? 5'h02 : 5'h01;
        end

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values
        start = errors;
        read_and_check(word_addr(4'd1, 6'h00), size_word);
        for (int i = 0; i < 8; i++) begin
            read_and_check(word_addr(4'd1, 6'(32 + 4 * i)), size_word);
        end
        read_and_check(word_addr(4'd2, 6'h04), size_word);
        read_and_check(word_addr(4'd2, 6'h08), size_word);
        @(negedge clk);
        check_byte("uo_out", uo_out, 8'h00);
        check_irq("irq", irq, '0);
        end_test("reset_defaults", start);

        // Edge pin 0 stays low during routing so the edge count stays put
        start = errors;
        repeat (6) begin
            bus_write(word_addr(4'd1, 6'h00), 32'($urandom), size_word);
            for (int i = 0; i < 8; i++) begin
                k = $urandom % 3;
                choice = (k == 0) ? 5'h01 : (k == 1) ? 5'h02 : 5'h10;
                bus_write(word_addr(4'd1, 6'(32 + 4 * i)), {27'h0, choice}, size_word);
            end
            @(posedge clk);
            ui_in <= 8'($urandom) & 8'hFE;
            @(negedge clk);
            m_ui = ui_in;
            check_byte("uo_out", uo_out, ref_uo());
            read_and_check(word_addr(4'd1, 6'h04), size_word);
            read_and_check(word_addr(4'd1, 6'(32 + 4 * ($urandom % 8))), size_word);
        end
        end_test("gpio_routing", start);

        // Reads of every word and byte slot with the handshake checked in bus_read
        start = errors;
        for (int s = 0; s < 16; s++) begin
            read_and_check(word_addr(4'(s), 6'h00), size_word);
            read_and_check(byte_addr(4'(s), 4'h0), size_byte);
        end
        end_test("read_protocol", start);

        // Timer match with auto-reload
        start = errors;
        n = 6 + ($urandom % 35);
        bus_write(word_addr(4'd1, 6'h20), 32'h02, size_word);
        bus_write(word_addr(4'd2, 6'h00), 32'h0, size_word);
        bus_write(word_addr(4'd2, 6'h04), 32'(n), size_word);
        bus_write(word_addr(4'd2, 6'h08), 32'h3, size_word);
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!irq.timer_irq && waits < n + 4);
        m_match_out = ~m_match_out;
        m_stat      = 1'b1;
        exp_irq           = '0;
        exp_irq.timer_irq = 1'b1;
        check_irq("irq", irq, exp_irq);
        check_byte("uo_out", uo_out, ref_uo());
        read_and_check(word_addr(4'd2, 6'h0C), size_word);
        bus_write(word_addr(4'd2, 6'h0C), 32'h1, size_word);
        @(negedge clk);
        check_irq("irq", irq, '0);
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!irq.timer_irq && waits <= n + 2);
        if (!irq.timer_irq) note_failure("Second timer match did not arrive in time");
        m_match_out = ~m_match_out;
        check_byte("uo_out", uo_out, ref_uo());
        bus_write(word_addr(4'd2, 6'h08), 32'h0, size_word);
        m_stat = 1'b0;
        bus_write(word_addr(4'd2, 6'h0C), 32'h1, size_word);
        end_test("timer_match", start);

        // Enough edges on the edge counter to wrap the 8-bit count
        start = errors;
        @(posedge clk);
        ui_in <= '0;
        m_ui = '0;
        repeat (3) @(posedge clk);
        pin = $urandom % 8;
        bus_write(byte_addr(4'd0, 4'h0), 32'(pin), size_byte);
        repeat (3) @(posedge clk);
        bus_write(byte_addr(4'd0, 4'h1), 32'h0, size_byte);
        k = 250 + ($urandom % 21);
        repeat (k) begin
            @(posedge clk);
            ui_in[pin] <= 1'b1;
            repeat (1 + ($urandom % 2)) @(posedge clk);
            ui_in[pin] <= 1'b0;
            repeat (2 + ($urandom % 2)) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        m_edge_cnt = 8'(k);
        read_and_check(byte_addr(4'd0, 4'h0), size_byte);
        read_and_check(byte_addr(4'd0, 4'h1), size_byte);
        bus_write(byte_addr(4'd0, 4'h1), 32'($urandom), size_byte);
        read_and_check(byte_addr(4'd0, 4'h1), size_byte);
        end_test("edge_counter", start);

        // Narrow writes to the compare register
        start = errors;
        bus_write(word_addr(4'd2, 6'h04), 32'($urandom), size_word);
        read_and_check(word_addr(4'd2, 6'h04), size_word);
        bus_write(word_addr(4'd2, 6'h04), 32'($urandom), size_byte);
        read_and_check(word_addr(4'd2, 6'h04), size_word);
        bus_write(word_addr(4'd2, 6'h04), 32'($urandom), size_half);
        read_and_check(word_addr(4'd2, 6'h04), size_word);
        end_test("write_sizes", start);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* periph_asserts.sv */
//==========================================================================
// Protocol and interrupt assertions bound into the subsystem top level
//==========================================================================
`default_nettype none

module periph_asserts (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire periph_pkg::bus_req_t req,
    input  wire                       data_ready,
    input  wire periph_pkg::irq_t     irq,
    input  wire                       tmr_enable,
    input  wire periph_pkg::bus_state_e fsm_state,
    input  wire  [31:0]               data_out
);
    timeunit 1ns;
    timeprecision 1ps;

    import periph_pkg::*;

    // data_ready only answers a live request
    ready_has_request: assert property (@(posedge clk) disable iff (!rst_n)
        data_ready |-> (req.read_size != size_none || req.write_size != size_none))
        else $error("data_ready is high with no request on the bus");

    irq_quiet_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        !tmr_enable |-> (irq == '0))
        else $error("irq is set while the timer is disabled");

    // Captured read data is held until the core completes the read
    data_held_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
        (fsm_state == st_wait_done) |-> $stable(data_out))
        else $error("data_out changed while waiting for read_complete");

endmodule

bind periph_subsystem periph_asserts i_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .data_ready (data_ready),
    .irq        (irq),
    .tmr_enable (u_timer.enable),
    .fsm_state  (u_bus_fsm.state),
    .data_out   (data_out)
);

`default_nettype wire

/* periph_subsystem.sv */
//==========================================================================
// Peripheral subsystem top with address decode, request gating and read mux
// Connects the core bus to the GPIO, timer and edge counter through the FSM
//==========================================================================
`default_nettype none

module periph_subsystem (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire periph_pkg::bus_req_t req,
    input  wire                      read_complete,
    input  wire  [7:0]               ui_in,
    output logic [31:0]              data_out,
    output logic                     data_ready,
    output logic [7:0]               uo_out,
    output periph_pkg::irq_t         irq
);
    import periph_pkg::*;

    logic                       read_req;
    logic                       write_req;
    logic                       rd_gate;
    access_size_e               rd_size_peri;
    logic                       is_byte;
    logic [3:0]                 word_slot;
    logic [3:0]                 byte_slot;
    logic [num_slots-1:0]       word_sel;
    logic [num_slots-1:0]       byte_sel;
    logic [31:0]                peri_data;
    logic                       peri_ready;
    logic [num_slots-1:0][31:0] word_rdata;
    logic [num_slots-1:0]       word_ready;
    logic [num_slots-1:0][7:0]  byte_rdata;
    logic [num_slots-1:0][7:0]  src_word;
    logic [num_slots-1:0][7:0]  src_byte;
    bus_req_t                   gpio_req;
    bus_req_t                   timer_req;
    logic [31:0]                gpio_rdata;
    logic [31:0]                timer_rdata;
    logic [7:0]                 timer_uo;
    logic                       timer_irq;
    logic [7:0]                 edge_rdata;
    logic [7:0]                 edge_uo;

    // Unselected peripherals see no access at all
    function automatic bus_req_t gate_req(
        input bus_req_t     r,
        input access_size_e rd_size,
        input logic         sel
    );
        bus_req_t g;
        g = r;
        g.read_size  = sel ? rd_size : size_none;
        g.write_size = sel ? r.write_size : size_none;
        return g;
    endfunction

    assign read_req  = (req.read_size != size_none);
    assign write_req = (req.write_size != size_none);
    assign is_byte   = req.address[10];
    assign word_slot = req.address[9:6];
    assign byte_slot = req.address[7:4];

    // Hide the read from peripherals while the FSM holds the result
    assign rd_size_peri = rd_gate ? size_none : req.read_size;

    always_comb begin
        word_sel = '0;
        byte_sel = '0;
        if (is_byte) begin
            byte_sel[byte_slot] = 1'b1;
        end else begin
            word_sel[word_slot] = 1'b1;
        end
    end

    assign gpio_req  = gate_req(req, rd_size_peri, word_sel[slot_gpio]);
    assign timer_req = gate_req(req, rd_size_peri, word_sel[slot_timer]);

    // Slot tables, empty slots read zero and answer at once
    always_comb begin
        word_rdata = '0;
        word_ready = '1;
        byte_rdata = '0;
        src_word   = '0;
        src_byte   = '0;
        word_rdata[slot_gpio]  = gpio_rdata;
        word_rdata[slot_timer] = timer_rdata;
        src_word[slot_timer]   = timer_uo;
        byte_rdata[slot_edge]  = edge_rdata;
        src_byte[slot_edge]    = edge_uo;
    end

    always_comb begin
        if (is_byte) begin
            peri_data  = {24'h0, byte_rdata[byte_slot]};
            peri_ready = 1'b1;
        end else begin
            peri_data  = word_rdata[word_slot];
            peri_ready = word_ready[word_slot];
        end
    end

    periph_bus_fsm u_bus_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .read_req      (read_req),
        .write_req     (write_req),
        .peri_data     (peri_data),
        .peri_ready    (peri_ready),
        .read_complete (read_complete),
        .data_out      (data_out),
        .data_ready    (data_ready),
        .rd_gate       (rd_gate)
    );

    periph_gpio u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (gpio_req),
        .ui_in    (ui_in),
        .src_word (src_word),
        .src_byte (src_byte),
        .rdata    (gpio_rdata),
        .uo_out   (uo_out)
    );

    periph_timer u_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (timer_req),
        .rdata  (timer_rdata),
        .uo_out (timer_uo),
        .irq    (timer_irq)
    );

    periph_edge_counter u_edge_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .ui_in      (ui_in),
        .address    (req.address[3:0]),
        .data_write (write_req && byte_sel[slot_edge]),
        .data_in    (req.wdata[7:0]),
        .data_out   (edge_rdata),
        .uo_out     (edge_uo)
    );

    always_comb begin
        irq           = '0;
        irq.timer_irq = timer_irq;
    end

endmodule

`default_nettype wire

/* periph_edge_counter.sv */
//==========================================================================
// Byte peripheral counting rising edges on one selectable input pin
// Offset 0 picks the pin, offset 1 reads the count and clears it on write
//==========================================================================
`default_nettype none

module periph_edge_counter (
    input  wire        clk,
    input  wire        rst_n,
    input  wire  [7:0] ui_in,
    input  wire  [3:0] address,
    input  wire        data_write,
    input  wire  [7:0] data_in,
    output logic [7:0] data_out,
    output logic [7:0] uo_out
);
    import periph_pkg::*;

    logic [2:0] pin_sel;
    logic [7:0] edge_count;
    logic       pin_sync;
    logic       pin_prev;
    logic       rise;

    assign rise = pin_sync && !pin_prev;

    // Sync stage plus the previous value for edge detection
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_sync <= 1'b0;
            pin_prev <= 1'b0;
        end else begin
            pin_sync <= ui_in[pin_sel];
            pin_prev <= pin_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_sel    <= '0;
            edge_count <= '0;
        end else begin
            if (data_write && address == edge_sel_off) begin
                pin_sel <= data_in[2:0];
            end
            if (data_write && address == edge_cnt_off) begin
                edge_count <= '0;
            end else if (rise) begin
                edge_count <= edge_count + 8'd1;
            end
        end
    end

    always_comb begin
        case (address)
            edge_sel_off: data_out = {5'h0, pin_sel};
            edge_cnt_off: data_out = edge_count;
            default:      data_out = '0;
        endcase
    end

    assign uo_out = edge_count;

endmodule

`default_nettype wire

/* periph_timer.sv */
//==========================================================================
// Compare timer word peripheral with auto-reload and match interrupt
// Match output toggles uo_out bit 0, status bit 0 is write one to clear
//==========================================================================
`default_nettype none

module periph_timer (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire periph_pkg::bus_req_t req,
    output logic [31:0]              rdata,
    output logic [7:0]               uo_out,
    output logic                     irq
);
    import periph_pkg::*;

    logic [31:0] count;
    logic [31:0] cmp;
    logic        enable;
    logic        auto_reload;
    logic        match_flag;
    logic        match_out;
    logic        hit;
    logic [5:0]  offset;
    logic        write_en;

    // Narrow writes replace only the low bytes
    function automatic logic [31:0] merge_write(
        input logic [31:0] old,
        input logic [31:0] wdata,
        input access_size_e size
    );
        logic [31:0] result;
        case (size)
            size_byte: result = {old[31:8], wdata[7:0]};
            size_half: result = {old[31:16], wdata[15:0]};
            default:   result = wdata;
        endcase
        return result;
    endfunction

    assign offset   = req.address[5:0];
    assign write_en = (req.write_size != size_none);
    assign hit      = enable && (count == cmp);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count       <= '0;
            cmp         <= '1;
            enable      <= 1'b0;
            auto_reload <= 1'b0;
            match_flag  <= 1'b0;
            match_out   <= 1'b0;
        end else begin
            if (hit) begin
                count      <= auto_reload ? 32'd0 : count + 32'd1;
                match_flag <= 1'b1;
                match_out  <= ~match_out;
            end else if (enable) begin
                count <= count + 32'd1;
            end
            // Bus writes override the counter update
            if (write_en) begin
                case (offset)
                    tmr_count_off: count <= merge_write(count, req.wdata, req.write_size);
                    tmr_cmp_off:   cmp <= merge_write(cmp, req.wdata, req.write_size);
                    tmr_ctrl_off: begin
                        enable      <= req.wdata[0];
                        auto_reload <= req.wdata[1];
                    end
                    tmr_stat_off: begin
                        // A new match in the same cycle wins over the clear
                        if (req.wdata[0] && !hit) begin
                            match_flag <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (req.read_size != size_none) begin
            case (offset)
                tmr_count_off: rdata = count;
                tmr_cmp_off:   rdata = cmp;
                tmr_ctrl_off:  rdata = {30'h0, auto_reload, enable};
                tmr_stat_off:  rdata = {31'h0, match_flag};
                default:       rdata = '0;
            endcase
        end
    end

    assign uo_out = {7'h0, match_out};
    assign irq    = match_flag && enable;

endmodule

`default_nettype wire

/* periph_gpio.sv */
//==========================================================================
// GPIO word peripheral with output register, input readback and routing
// Each uo_out pin takes its bit from the peripheral named by its select
//==========================================================================
`default_nettype none

module periph_gpio (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire periph_pkg::bus_req_t req,
    input  wire  [7:0]               ui_in,
    input  wire  [15:0][7:0]         src_word,
    input  wire  [15:0][7:0]         src_byte,
    output logic [31:0]              rdata,
    output logic [7:0]               uo_out
);
    import periph_pkg::*;

    logic [7:0]                 gpio_out;
    func_sel_t [num_pins-1:0]   sel_q;
    logic [5:0]                 offset;
    logic                       write_en;
    logic                       read_en;

    function automatic logic [5:0] sel_offset(input int pin);
        return 6'(gpio_sel_base + pin * gpio_sel_stride);
    endfunction

    assign offset   = req.address[5:0];
    assign write_en = (req.write_size != size_none);
    assign read_en  = (req.read_size != size_none);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (write_en && offset == gpio_out_off) begin
            gpio_out <= req.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= sel_reset_default;
        end else if (write_en) begin
            for (int i = 0; i < num_pins; i++) begin
                if (offset == sel_offset(i)) begin
                    sel_q[i] <= req.wdata[4:0];
                end
            end
        end
    end

    // Register readback, zero for unmapped offsets
    always_comb begin
        rdata = '0;
        if (read_en) begin
            if (offset == gpio_out_off) begin
                rdata = {24'h0, gpio_out};
            end else if (offset == gpio_in_off) begin
                rdata = {24'h0, ui_in};
            end
            for (int i = 0; i < num_pins; i++) begin
                if (offset == sel_offset(i)) begin
                    rdata = {27'h0, sel_q[i]};
                end
            end
        end
    end

    // Output routing, bit i of the chosen source drives pin i
    always_comb begin
        for (int i = 0; i < num_pins; i++) begin
            if (sel_q[i].byte_sel) begin
                uo_out[i] = src_byte[sel_q[i].slot][i];
            end else if (sel_q[i].slot == slot_gpio) begin
                uo_out[i] = gpio_out[i];
            end else begin
                uo_out[i] = src_word[sel_q[i].slot][i];
            end
        end
    end

endmodule

`default_nettype wire

/* periph_bus_fsm.sv */
//==========================================================================
// Read handshake FSM between the core and the peripheral read data mux
// Captures read data once, then holds it until the core signals completion
//==========================================================================
`default_nettype none

module periph_bus_fsm (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         read_req,
    input  wire         write_req,
    input  wire  [31:0] peri_data,
    input  wire         peri_ready,
    input  wire         read_complete,
    output logic [31:0] data_out,
    output logic        data_ready,
    output logic        rd_gate
);
    import periph_pkg::*;

    bus_state_e  state;
    bus_state_e  state_next;
    logic [31:0] data_q;
    logic        capture;

    // Take the peripheral data on the first cycle a read is seen
    assign capture = (state == st_idle) && read_req && peri_ready;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (capture) begin
                    state_next = st_hold;
                end
            end
            st_hold: begin
                // Completion normally arrives in st_wait_done
                if (read_complete) begin
                    state_next = st_idle;
                end else begin
                    state_next = st_wait_done;
                end
            end
            st_wait_done: begin
                if (read_complete) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= peri_data;
        end
    end

    assign data_out = data_q;

    // Writes are acknowledged in the cycle they are presented
    assign data_ready = (state == st_hold) || write_req;

    // Peripherals see the read only while idle
    assign rd_gate = (state != st_idle);

endmodule

`default_nettype wire

/* periph_pkg.sv */
//==========================================================================
// Shared types and address map for the peripheral subsystem
// Imported by the bus FSM, the peripherals, the top level and the testbench
//==========================================================================
`default_nettype none

package periph_pkg;

    localparam int num_slots = 16;
    localparam int num_pins  = 8;

    // Core size code, same encoding as the TinyQV data_read_n / data_write_n
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10,
        size_none = 2'b11
    } access_size_e;

    typedef struct packed {
        logic [10:0]  address;
        logic [31:0]  wdata;
        access_size_e write_size;
        access_size_e read_size;
    } bus_req_t;

    typedef enum logic [1:0] {
        st_idle,
        st_hold,
        st_wait_done
    } bus_state_e;

    typedef struct packed {
        logic [6:0] reserved;
        logic       timer_irq;
    } irq_t;

    // Output source code for one uo_out pin
    typedef struct packed {
        logic       byte_sel;
        logic [3:0] slot;
    } func_sel_t;

    // Word slots sit at address bits 9..6, byte slots at 7..4 with bit 10 set
    localparam logic [3:0] slot_edge  = 4'd0;
    localparam logic [3:0] slot_gpio  = 4'd1;
    localparam logic [3:0] slot_timer = 4'd2;

    localparam logic [5:0] gpio_out_off    = 6'h00;
    localparam logic [5:0] gpio_in_off     = 6'h04;
    localparam logic [5:0] gpio_sel_base   = 6'h20;
    localparam int         gpio_sel_stride = 4;

    localparam logic [5:0] tmr_count_off = 6'h00;
    localparam logic [5:0] tmr_cmp_off   = 6'h04;
    localparam logic [5:0] tmr_ctrl_off  = 6'h08;
    localparam logic [5:0] tmr_stat_off  = 6'h0C;

    localparam logic [3:0] edge_sel_off = 4'h0;
    localparam logic [3:0] edge_cnt_off = 4'h1;

    localparam func_sel_t sel_gpio  = '{byte_sel: 1'b0, slot: slot_gpio};
    localparam func_sel_t sel_timer = '{byte_sel: 1'b0, slot: slot_timer};

    // Pin 0 carries the timer match output, the rest are plain GPIO
    localparam func_sel_t [num_pins-1:0] sel_reset_default =
        {{(num_pins - 1){sel_gpio}}, sel_timer};

endpackage

`default_nettype wire
